// File: design/usb_status_pkg.sv
package usb_status_pkg;

  // Device state as reported by the protocol engine
  typedef enum logic [3:0] {
    USB_POWERED    = 4'h0,
    USB_DEFAULT    = 4'h1,
    USB_ADDRESS    = 4'h2,
    USB_CONFIGURED = 4'h3,
    USB_SUSPENDED  = 4'h4
  } usb_state_e;

  // Control endpoint transfer phase
  typedef enum logic [3:0] {
    CTL_IDLE     = 4'h0,
    CTL_SETUP    = 4'h1,
    CTL_DATA_IN  = 4'h2,
    CTL_DATA_OUT = 4'h3,
    CTL_STATUS   = 4'h4
  } ctl_state_e;

  // Live protocol snapshot of 17 bits
  typedef struct packed {
    logic       crc_error;
    usb_state_e usb_state;
    ctl_state_e ctl_state;
    logic [7:0] blk_state;
  } usb_status_t;

endpackage

// File: design/telemetry_pkg.sv
package telemetry_pkg;

  // Framing of the record stream
  localparam int FRAME_RECORDS    = 8;
  localparam int BYTES_PER_RECORD = 3;

  // Endpoint number that addresses the telemetry stream
  localparam logic [3:0] TELEM_ENDPOINT = 4'd2;

  // 64 records by default
  localparam int FIFO_ABITS_DEFAULT = 6;

  // One captured status change
  typedef struct packed {
    logic                        last;
    usb_status_pkg::usb_status_t status;
  } telem_rec_t;

  // One byte on the stream toward the USB transmitter
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } byte_beat_t;

endpackage

// File: design/telemetry_capture.sv
`timescale 1ns/1ps

module telemetry_capture (
  input  logic                        clock,
  input  logic                        reset,

  input  logic                        usb_enum_i,
  input  usb_status_pkg::usb_status_t status_i,

  output logic                        rec_valid_o,
  output telemetry_pkg::telem_rec_t   rec_o,
  input  logic                        rec_ready_i
);

  localparam int CBITS = $clog2(telemetry_pkg::FRAME_RECORDS);

  usb_status_pkg::usb_status_t prev_q;
  logic [CBITS-1:0]            count_q;
  logic                        rec_fire;

  // A change is judged against last cycle's snapshot
  assign rec_valid_o = usb_enum_i && (status_i != prev_q);
  assign rec_fire    = rec_valid_o && rec_ready_i;

  assign rec_o.status = status_i;
  assign rec_o.last   = (count_q == CBITS'(telemetry_pkg::FRAME_RECORDS - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      prev_q <= '0;
    end else begin
      prev_q <= status_i;
    end
  end

  // Counts records within a frame and wraps after the eighth
  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
    end else if (rec_fire) begin
      count_q <= count_q + 1'b1;
    end
  end

  // Dropped changes must not shift the framing
  a_count_on_fire: assert property (
    @(posedge clock) disable iff (reset)
    !rec_fire |=> $stable(count_q)
  ) else $error("record counter moved without a FIFO handshake");

endmodule

// File: design/telemetry_fifo.sv
`timescale 1ns/1ps

module telemetry_fifo #(
  parameter int ABITS = telemetry_pkg::FIFO_ABITS_DEFAULT
) (
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      wr_valid_i,
  input  telemetry_pkg::telem_rec_t wr_rec_i,
  output logic                      wr_ready_o,

  output logic                      rd_valid_o,
  output telemetry_pkg::telem_rec_t rd_rec_o,
  input  logic                      rd_ready_i,

  output logic [ABITS:0]            level_o
);

  localparam logic [ABITS:0] DEPTH = {1'b1, {ABITS{1'b0}}};

  telemetry_pkg::telem_rec_t mem [2**ABITS];

  logic [ABITS:0]            wr_ptr_q;
  logic [ABITS:0]            rd_ptr_q;
  logic [ABITS:0]            level_q;
  logic [ABITS:0]            ram_used;
  logic                      ram_empty;
  logic                      out_valid_q;
  telemetry_pkg::telem_rec_t out_rec_q;
  logic                      wr_fire;
  logic                      rd_fire;
  logic                      load;

  // Level covers the RAM and the output register together
  assign wr_ready_o = (level_q != DEPTH);
  assign wr_fire    = wr_valid_i && wr_ready_o;
  assign rd_fire    = out_valid_q && rd_ready_i;

  assign ram_used  = wr_ptr_q - rd_ptr_q;
  assign ram_empty = (ram_used == '0);

  // Refill the output register when it is empty or being drained
  assign load = !ram_empty && (!out_valid_q || rd_ready_i);

  assign rd_valid_o = out_valid_q;
  assign rd_rec_o   = out_rec_q;
  assign level_o    = level_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      level_q     <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (load) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_fire, rd_fire})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
      if (load) begin
        out_valid_q <= 1'b1;
      end else if (rd_fire) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr_fire) begin
      mem[wr_ptr_q[ABITS-1:0]] <= wr_rec_i;
    end
    if (load) begin
      out_rec_q <= mem[rd_ptr_q[ABITS-1:0]];
    end
  end

  a_no_write_full: assert property (
    @(posedge clock) disable iff (reset)
    wr_fire |-> (ram_used < DEPTH)
  ) else $error("write into a full record RAM");

  // Level stays in range and matches what is actually held
  a_level_bound: assert property (
    @(posedge clock) disable iff (reset)
    (level_q <= DEPTH) && (level_q == ram_used + out_valid_q)
  ) else $error("FIFO level out of range or out of step with pointers");

endmodule

// File: design/record_serializer.sv
`timescale 1ns/1ps

module record_serializer (
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      rec_valid_i,
  input  telemetry_pkg::telem_rec_t rec_i,
  output logic                      rec_ready_o,

  output logic                      beat_valid_o,
  output telemetry_pkg::byte_beat_t beat_o,
  input  logic                      beat_ready_i
);

  localparam int IBITS = $clog2(telemetry_pkg::BYTES_PER_RECORD);

  typedef enum logic [IBITS-1:0] {
    BYTE0,
    BYTE1,
    BYTE2
  } byte_idx_e;

  byte_idx_e                 idx_q;
  logic                      hold_valid_q;
  telemetry_pkg::telem_rec_t hold_rec_q;
  logic                      beat_fire;
  logic                      rec_done;
  logic                      rec_fire;

  assign beat_valid_o = hold_valid_q;
  assign beat_fire    = beat_valid_o && beat_ready_i;
  assign rec_done     = beat_fire && (idx_q == BYTE2);

  // Next record may enter as the last byte of the current one leaves
  assign rec_ready_o = !hold_valid_q || rec_done;
  assign rec_fire    = rec_valid_i && rec_ready_o;

  always_comb begin
    beat_o.last = 1'b0;
    case (idx_q)
      BYTE0: beat_o.data = hold_rec_q.status.blk_state;
      BYTE1: beat_o.data = {hold_rec_q.status.usb_state, hold_rec_q.status.ctl_state};
      default: begin
        beat_o.data = {7'b0, hold_rec_q.status.crc_error};
        beat_o.last = hold_rec_q.last;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      hold_valid_q <= 1'b0;
      idx_q        <= BYTE0;
    end else begin
      if (rec_fire) begin
        hold_valid_q <= 1'b1;
      end else if (rec_done) begin
        hold_valid_q <= 1'b0;
      end
      if (beat_fire) begin
        case (idx_q)
          BYTE0:   idx_q <= BYTE1;
          BYTE1:   idx_q <= BYTE2;
          default: idx_q <= BYTE0;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rec_fire) begin
      hold_rec_q <= rec_i;
    end
  end

  // Stalled byte must not move
  a_beat_stable: assert property (
    @(posedge clock) disable iff (reset)
    beat_valid_o && !beat_ready_i |=> beat_valid_o && $stable(beat_o)
  ) else $error("byte changed while stalled");

endmodule

// File: design/bulk_in_select.sv
`timescale 1ns/1ps

module bulk_in_select (
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      usb_enum_i,
  input  logic                      start_i,
  input  logic                      select_i,
  input  logic [3:0]                endpt_i,

  input  logic                      beat_valid_i,
  input  telemetry_pkg::byte_beat_t beat_i,
  output logic                      beat_ready_o,

  output logic                      m_valid_o,
  output telemetry_pkg::byte_beat_t m_beat_o,
  input  logic                      m_ready_i
);

  logic sel_q;
  logic qualify;
  logic frame_end;

  // IN token addressed to the telemetry endpoint
  assign qualify = usb_enum_i && start_i && select_i &&
                   (endpt_i == telemetry_pkg::TELEM_ENDPOINT);

  assign m_valid_o    = sel_q && beat_valid_i;
  assign beat_ready_o = sel_q && m_ready_i;
  assign m_beat_o     = beat_i;

  assign frame_end = m_valid_o && m_ready_i && m_beat_o.last;

  always_ff @(posedge clock) begin
    if (reset) begin
      sel_q <= 1'b0;
    end else if (qualify) begin
      sel_q <= 1'b1;
    end else if (frame_end) begin
      sel_q <= 1'b0;
    end
  end

  // Stream only opens after a qualifying token
  a_idle_quiet: assert property (
    @(posedge clock) disable iff (reset)
    !sel_q && !qualify |=> !m_valid_o
  ) else $error("byte offered without endpoint select");

endmodule

// File: design/bulk_telemetry.sv
`timescale 1ns/1ps

module bulk_telemetry #(
  parameter int FIFO_ABITS = telemetry_pkg::FIFO_ABITS_DEFAULT
) (
  input  logic                        clock,
  input  logic                        reset,

  input  logic                        usb_enum_i,
  input  usb_status_pkg::usb_status_t status_i,

  input  logic                        start_i,
  input  logic                        select_i,
  input  logic [3:0]                  endpt_i,

  output logic                        m_valid_o,
  output telemetry_pkg::byte_beat_t   m_beat_o,
  input  logic                        m_ready_i,

  output logic [FIFO_ABITS:0]         level_o
);

  // Capture to FIFO
  logic                      cap_valid;
  telemetry_pkg::telem_rec_t cap_rec;
  logic                      cap_ready;

  // FIFO to serializer
  logic                      fifo_valid;
  telemetry_pkg::telem_rec_t fifo_rec;
  logic                      fifo_ready;

  // Serializer to endpoint select
  logic                      ser_valid;
  telemetry_pkg::byte_beat_t ser_beat;
  logic                      ser_ready;

  telemetry_capture u_capture0 (
    .clock       (clock),
    .reset       (reset),
    .usb_enum_i  (usb_enum_i),
    .status_i    (status_i),
    .rec_valid_o (cap_valid),
    .rec_o       (cap_rec),
    .rec_ready_i (cap_ready)
  );

  telemetry_fifo #(
    .ABITS (FIFO_ABITS)
  ) u_fifo0 (
    .clock      (clock),
    .reset      (reset),
    .wr_valid_i (cap_valid),
    .wr_rec_i   (cap_rec),
    .wr_ready_o (cap_ready),
    .rd_valid_o (fifo_valid),
    .rd_rec_o   (fifo_rec),
    .rd_ready_i (fifo_ready),
    .level_o    (level_o)
  );

  record_serializer u_serializer0 (
    .clock        (clock),
    .reset        (reset),
    .rec_valid_i  (fifo_valid),
    .rec_i        (fifo_rec),
    .rec_ready_o  (fifo_ready),
    .beat_valid_o (ser_valid),
    .beat_o       (ser_beat),
    .beat_ready_i (ser_ready)
  );

  bulk_in_select u_select0 (
    .clock        (clock),
    .reset        (reset),
    .usb_enum_i   (usb_enum_i),
    .start_i      (start_i),
    .select_i     (select_i),
    .endpt_i      (endpt_i),
    .beat_valid_i (ser_valid),
    .beat_i       (ser_beat),
    .beat_ready_o (ser_ready),
    .m_valid_o    (m_valid_o),
    .m_beat_o     (m_beat_o),
    .m_ready_i    (m_ready_i)
  );

endmodule

// File: tb/tb_bulk_telemetry.sv
`timescale 1ns/1ps

module tb_bulk_telemetry;

  localparam int ABITS        = telemetry_pkg::FIFO_ABITS_DEFAULT;
  localparam int DEPTH        = 1 << ABITS;
  localparam int POS_BITS     = $clog2(telemetry_pkg::FRAME_RECORDS);
  localparam int FRAME_BYTES  = telemetry_pkg::FRAME_RECORDS * telemetry_pkg::BYTES_PER_RECORD;
  localparam int RESET_CYCLES = 8;
  localparam int FILL_CHANGES = 80;
  localparam int FRAME_WAIT   = 8 * FRAME_BYTES;
  localparam logic [ABITS:0] FULL_LEVEL = (ABITS+1)'(DEPTH);
  // Reset, level steps, bad tokens, eleven frames at half rate, the fill burst
  localparam int STIM_CYCLES     = RESET_CYCLES + 64 + 32 + 11 * 2 * FRAME_BYTES +
                                   FILL_CHANGES + 40;
  localparam int WATCHDOG_CYCLES = 2 * STIM_CYCLES + 200;

  typedef struct packed {
    logic [POS_BITS-1:0]         pos;
    usb_status_pkg::usb_status_t status;
  } exp_rec_t;

  typedef telemetry_pkg::byte_beat_t [2:0] rec_bytes_t;

  logic                        clock;
  logic                        reset;
  logic                        usb_enum_i;
  usb_status_pkg::usb_status_t status_i;
  logic                        start_i;
  logic                        select_i;
  logic [3:0]                  endpt_i;
  logic                        m_valid_o;
  telemetry_pkg::byte_beat_t   m_beat_o;
  logic                        m_ready_i;
  logic [ABITS:0]              level_o;

  exp_rec_t            rec_q[$];
  logic [POS_BITS-1:0] frame_pos = '0;
  logic [1:0]          byte_idx = 2'd0;
  int                  accept_left = 4 * DEPTH;
  // Expected level_o while the stream is closed
  int                  exp_level = 0;
  int                  seq = 1;
  int                  bytes_seen = 0;
  int                  frames_seen = 0;
  int                  value_errors = 0;
  int                  other_errors = 0;
  int                  mon_value_errors = 0;
  int                  mon_other_errors = 0;

  bulk_telemetry dut0 (.*);

  initial begin : clock_gen
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Three bytes of one record in stream order
  function automatic rec_bytes_t expand_record(input usb_status_pkg::usb_status_t st,
                                               input logic [POS_BITS-1:0] pos);
    rec_bytes_t beats;
    beats[0].last = 1'b0;
    beats[0].data = st.blk_state;
    beats[1].last = 1'b0;
    beats[1].data = {st.usb_state, st.ctl_state};
    beats[2].last = (int'(pos) == telemetry_pkg::FRAME_RECORDS - 1);
    beats[2].data = {7'b0, st.crc_error};
    return beats;
  endfunction

  // blk_state follows seq, so neighbours always differ
  function automatic usb_status_pkg::usb_status_t next_status();
    usb_status_pkg::usb_status_t st;
    st.crc_error = 1'($urandom);
    st.usb_state = usb_status_pkg::usb_state_e'(4'(seq % 5));
    st.ctl_state = usb_status_pkg::ctl_state_e'(4'($urandom % 5));
    st.blk_state = 8'(seq);
    seq++;
    return st;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic check_level(input logic [ABITS:0] expected);
    if (level_o !== expected) begin
      value_errors++;
      $display("Error: level_o expected 0x%0h got 0x%0h at %0t", expected, level_o, $time);
    end
  endtask

  task automatic check_quiet(input int n);
    repeat (n) begin
      if (m_valid_o !== 1'b0) begin
        value_errors++;
        $display("Error: m_valid_o expected 0x0 got 0x%0h at %0t", m_valid_o, $time);
      end
      wait_cycles(1);
    end
  endtask

  task automatic apply_status(input usb_status_pkg::usb_status_t st, input bit check_lvl);
    bit       expect_rec;
    exp_rec_t rec;
    expect_rec = usb_enum_i && (st != status_i);
    status_i   = st;
    if (expect_rec && accept_left > 0) begin
      rec.pos    = frame_pos;
      rec.status = st;
      rec_q.push_back(rec);
      frame_pos   = frame_pos + 1'b1;
      accept_left = accept_left - 1;
      exp_level   = exp_level + 1;
    end
    wait_cycles(1);
    if (check_lvl) begin
      check_level((ABITS+1)'(exp_level));
    end
  endtask

  task automatic pulse_start(input logic [3:0] ep, input logic sel, input logic en);
    start_i    = 1'b1;
    endpt_i    = ep;
    select_i   = sel;
    usb_enum_i = en;
    wait_cycles(1);
    start_i    = 1'b0;
    select_i   = 1'b0;
    usb_enum_i = 1'b1;
  endtask

  task automatic wait_frame_end(input int target, input bit random_ready);
    int cycles;
    cycles = 0;
    while (frames_seen < target && cycles < FRAME_WAIT) begin
      if (random_ready) begin
        m_ready_i = 1'($urandom);
      end
      wait_cycles(1);
      cycles++;
    end
    m_ready_i = 1'b1;
    if (frames_seen < target) begin
      other_errors++;
      $display("frame %0d did not end within %0d cycles", target, FRAME_WAIT);
    end else if (bytes_seen != target * FRAME_BYTES) begin
      other_errors++;
      $display("%0d bytes streamed by the end of frame %0d, %0d expected",
               bytes_seen, target, target * FRAME_BYTES);
    end
  endtask

  // Sampled mid-cycle, the transfer completes on the next rising edge
  always @(negedge clock) begin : byte_monitor
    exp_rec_t   head;
    rec_bytes_t beats;
    if (!reset && m_valid_o && m_ready_i) begin
      bytes_seen++;
      if (m_beat_o.last) begin
        frames_seen++;
      end
      if (rec_q.size() == 0) begin
        mon_other_errors++;
        $display("byte 0x%02h arrived with no record left to stream", m_beat_o.data);
      end else begin
        head  = rec_q[0];
        beats = expand_record(head.status, head.pos);
        if (m_beat_o.data !== beats[byte_idx].data) begin
          mon_value_errors++;
          $display("Error: m_beat_o.data expected 0x%02h got 0x%02h at %0t",
                   beats[byte_idx].data, m_beat_o.data, $time);
        end
        if (m_beat_o.last !== beats[byte_idx].last) begin
          mon_value_errors++;
          $display("Error: m_beat_o.last expected 0x%0h got 0x%0h at %0t",
                   beats[byte_idx].last, m_beat_o.last, $time);
        end
        if (byte_idx == 2'd2) begin
          rec_q.delete(0);
          byte_idx = 2'd0;
        end else begin
          byte_idx = byte_idx + 1'b1;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
    $display("checks done: %0d value errors, %0d other errors",
             value_errors + mon_value_errors, other_errors + mon_other_errors + 1);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    int i;
    void'($urandom(5001));
    reset      = 1'b1;
    usb_enum_i = 1'b0;
    status_i   = '0;
    start_i    = 1'b0;
    select_i   = 1'b0;
    endpt_i    = 4'd0;
    m_ready_i  = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;
    check_quiet(1);
    check_level('0);
    usb_enum_i = 1'b1;

    // First record moves on into the serializer and leaves the FIFO level
    apply_status(next_status(), 1'b1);
    wait_cycles(3);
    exp_level = exp_level - 1;
    for (i = 0; i < 15; i++) begin
      apply_status(next_status(), 1'b1);
      apply_status(status_i, 1'b1);
    end
    usb_enum_i = 1'b0;
    for (i = 0; i < 4; i++) begin
      apply_status(next_status(), 1'b1);
    end
    usb_enum_i = 1'b1;
    apply_status(status_i, 1'b1);

    // Tokens that must not open the stream
    pulse_start(4'd3, 1'b1, 1'b1);
    check_quiet(6);
    pulse_start(telemetry_pkg::TELEM_ENDPOINT, 1'b0, 1'b1);
    check_quiet(6);
    pulse_start(telemetry_pkg::TELEM_ENDPOINT, 1'b1, 1'b0);
    check_quiet(6);

    pulse_start(telemetry_pkg::TELEM_ENDPOINT, 1'b1, 1'b1);
    wait_frame_end(1, 1'b0);
    check_quiet(6);

    // Back-pressure while new changes keep arriving
    pulse_start(telemetry_pkg::TELEM_ENDPOINT, 1'b1, 1'b1);
    for (i = 0; i < 8; i++) begin
      m_ready_i = 1'($urandom);
      apply_status(next_status(), 1'b0);
    end
    wait_frame_end(2, 1'b1);
    pulse_start(telemetry_pkg::TELEM_ENDPOINT, 1'b1, 1'b1);
    wait_frame_end(3, 1'b1);

    // Fill with the stream idle, then read back full frames only
    accept_left = DEPTH;
    for (i = 0; i < FILL_CHANGES; i++) begin
      apply_status(next_status(), 1'b0);
    end
    check_quiet(3);
    check_level(FULL_LEVEL);
    for (i = 0; i < DEPTH / telemetry_pkg::FRAME_RECORDS; i++) begin
      pulse_start(telemetry_pkg::TELEM_ENDPOINT, 1'b1, 1'b1);
      wait_frame_end(4 + i, 1'b0);
    end
    check_quiet(10);
    if (rec_q.size() != 0) begin
      other_errors++;
      $display("%0d queued records were never streamed", rec_q.size());
    end

    $display("checks done: %0d value errors, %0d other errors",
             value_errors + mon_value_errors, other_errors + mon_other_errors);
    if (value_errors + mon_value_errors + other_errors + mon_other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
design/usb_status_pkg.sv
design/telemetry_pkg.sv
design/telemetry_capture.sv
design/telemetry_fifo.sv
design/record_serializer.sv
design/bulk_in_select.sv
design/bulk_telemetry.sv
tb/tb_bulk_telemetry.sv
